//--- Bender.yml
package:
  name: motor_pwm

sources:
  - include_dirs:
      - .
    files:
      - motorPwm_pkg.sv
      - stepTimer.sv
      - stepSequencer.sv
      - pwmGenerator.sv
      - motorPwmTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbClock.sv
      - motorPwm_assert.sv
      - motorPwmTb.sv

//--- list.f
+incdir+.
motorPwm_pkg.sv
stepTimer.sv
stepSequencer.sv
pwmGenerator.sv
motorPwmTop.sv
tbClock.sv
motorPwm_assert.sv
motorPwmTb.sv

//--- motorPwmTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "motorPwm_cfg.svh"

module motorPwmTb;

    localparam int CLK_PERIOD_NS = 20;
    localparam int RUN_COUNT = 9;
    localparam int MAX_WINDOW = 3000;
    localparam int MAX_RUN_STEPS = 14;
    localparam int IDLE_CYCLES = 40;
    // reset and idle stretch, then every run at its longest with the stop window and idle gap
    localparam int PLANNED_CYCLES = 10 + IDLE_CYCLES
        + RUN_COUNT * ((MAX_RUN_STEPS + 3) * MAX_WINDOW + IDLE_CYCLES);
    localparam int MARGIN_CYCLES = 2000;

    wire logic clk;
    wire logic reset;
    logic start;
    logic stop;
    motorPwm_pkg::window_t windowLen;
    motorPwm_pkg::pwmLen_t pwmLenWant;
    motorPwm_pkg::pos_t plLen;
    wire logic pwm;
    wire logic running;
    wire motorPwm_pkg::step_t step;
    wire motorPwm_pkg::pos_t lostCount;

    // cycle model state, advanced on every rising edge
    motorPwm_pkg::seqState_t modelState;
    motorPwm_pkg::step_t modelStep;
    motorPwm_pkg::window_t modelWinCnt;
    motorPwm_pkg::pwmLen_t modelPeriod;
    motorPwm_pkg::pos_t modelRemainder, modelPulse, modelWant, modelReal, modelLossDiff, modelLost;
    logic modelWl1Q, modelReloadQ, modelWlQ;
    logic modelValid = 1'b0;
    logic expRunning;
    logic expPwm;

    assign expRunning = (modelState != motorPwm_pkg::Idle);
    assign expPwm = expRunning && (modelPulse != '0);

    tbClock i_tbClock (.clk(clk), .reset(reset));

    motorPwmTop i_dut (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .stop       (stop),
        .windowLen  (windowLen),
        .pwmLenWant (pwmLenWant),
        .plLen      (plLen),
        .pwm        (pwm),
        .running    (running),
        .step       (step),
        .lostCount  (lostCount)
    );

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "check failed");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        reportFailure($sformatf("Error at %0t ns: %s is %0h, expected %0h",
                                $time, name, got, expected));
    endtask

    // every value is taken from the old state before any of it is overwritten
    task automatic advanceModel();
        logic run;
        logic wl1;
        logic wl;
        logic reload;
        logic periodStart;
        logic sumLoad;
        logic pwmNow;
        motorPwm_pkg::pos_t posSum;
        motorPwm_pkg::seqState_t stateNext;
        run = (modelState != motorPwm_pkg::Idle);
        wl1 = run && (modelWinCnt == windowLen - 2);
        wl = run && (modelWinCnt == windowLen - 1);
        reload = !run || modelWl1Q || (modelPeriod == 1) || (plLen == 0);
        periodStart = modelReloadQ && !reload;
        posSum = modelRemainder + plLen;
        sumLoad = (posSum >= `PWM_MIN_ON);
        pwmNow = run && (modelPulse != 0);
        stateNext = modelState;
        if (modelState == motorPwm_pkg::Idle && start)
            stateNext = motorPwm_pkg::Run;
        else if (modelState == motorPwm_pkg::Run && stop)
            stateNext = motorPwm_pkg::Stopping;
        else if (modelState == motorPwm_pkg::Stopping && wl)
            stateNext = motorPwm_pkg::Idle;
        if (reset) begin
            modelState = motorPwm_pkg::Idle;
            {modelStep, modelWinCnt, modelPeriod} = '0;
            {modelRemainder, modelPulse, modelWant, modelReal, modelLossDiff, modelLost} = '0;
            {modelWl1Q, modelReloadQ, modelWlQ} = '0;
            modelValid = 1'b1;
        end else begin
            // by now the step has moved on, so the restart is on entering step 0 or 6
            if (modelWlQ) begin
                if (modelStep == `LOSS_RESET_STEP_A || modelStep == `LOSS_RESET_STEP_B)
                    modelLost = modelLossDiff;
                else
                    modelLost = modelLost + modelLossDiff;
            end
            modelWlQ = wl;
            if (wl)
                modelLossDiff = modelWant - modelReal;
            modelWant = (wl || !run) ? 0 : modelWant + (periodStart ? plLen : 0);
            modelReal = (wl || !run) ? 0 : modelReal + pwmNow;
            if (!run)
                modelRemainder = 0;
            else if (periodStart)
                modelRemainder = sumLoad ? 0 : posSum;
            if (!run)
                modelPulse = 0;
            else if (periodStart && sumLoad)
                modelPulse = posSum;
            else if (modelPulse != 0)
                modelPulse = modelPulse - 1;
            modelPeriod = reload ? pwmLenWant : modelPeriod - 1;
            modelReloadQ = reload;
            modelWl1Q = wl1;
            if (modelState == motorPwm_pkg::Idle && start)
                modelStep = 0;
            else if (modelState == motorPwm_pkg::Run && wl)
                modelStep = (modelStep == `STEP_COUNT - 1) ? 0 : modelStep + 1;
            modelState = stateNext;
            modelWinCnt = (!run || modelWinCnt == windowLen - 1) ? 0 : modelWinCnt + 1;
        end
    endtask

    always @(posedge clk) begin
        advanceModel();
    end

    // all outputs come from registers, so half a cycle after the edge they are settled
    always @(negedge clk) begin
        if (modelValid) begin
            assert (running === expRunning) else reportMismatch("running", running, expRunning);
            assert (pwm === expPwm) else reportMismatch("pwm", pwm, expPwm);
            assert (step === modelStep) else reportMismatch("step", step, modelStep);
            assert (lostCount === modelLost)
                else reportMismatch("lostCount", lostCount, modelLost);
        end
    end

    // mode 0 keeps pulses short, mode 1 fits one pulse per period, mode 2 mixes in zeros
    function automatic motorPwm_pkg::pos_t drawPlLen(input int mode);
        case (mode)
            0: return $urandom_range(`PWM_MIN_ON - 1, 0);
            1: return $urandom_range(pwmLenWant - 1, `PWM_MIN_ON);
            default: return ($urandom_range(5, 0) == 0) ? 0 : $urandom_range(700, 0);
        endcase
    endfunction

    task automatic driveCycle(input int mode);
        @(negedge clk);
        start = 1'b0;
        stop = 1'b0;
        if ($urandom_range(31, 0) == 0)
            plLen = drawPlLen(mode);
    endtask

    task automatic runSequence(input int mode, input int steps);
        int unsigned waited;
        @(negedge clk);
        windowLen = $urandom_range(MAX_WINDOW, 4);
        pwmLenWant = (mode == 1) ? $urandom_range(600, 300) : $urandom_range(600, 2);
        plLen = drawPlLen(mode);
        start = 1'b1;
        repeat (steps * windowLen + $urandom_range(windowLen - 1, 0)) driveCycle(mode);
        @(negedge clk);
        stop = 1'b1;
        waited = 0;
        // the stop only lets the current window run out
        while (running && waited <= windowLen + 1) begin
            driveCycle(mode);
            waited++;
        end
        assert (!running)
            else reportFailure("running stayed high for more than one window after stop");
    endtask

    initial begin
        void'($urandom(32'ha4a354b5));
        start = 1'b0;
        stop = 1'b0;
        windowLen = 16;
        pwmLenWant = 100;
        plLen = '0;
        wait (reset === 1'b0);
        // pulse requests while idle must not reach the output
        repeat (IDLE_CYCLES) driveCycle(2);
        for (int runIdx = 0; runIdx < RUN_COUNT; runIdx++) begin
            runSequence(runIdx % 3,
                        (runIdx % 3 == 2) ? MAX_RUN_STEPS : $urandom_range(MAX_RUN_STEPS, 1));
            repeat (IDLE_CYCLES) driveCycle(runIdx % 3);
        end
        @(negedge clk);
        $display("Finished with no errors");
        $finish;
    end

    initial begin
        #(CLK_PERIOD_NS * (PLANNED_CYCLES + MARGIN_CYCLES));
        $display("Finished with errors");
        $fatal(1, "run did not finish within the planned number of cycles");
    end

endmodule

`default_nettype wire

//--- motorPwmTop.sv
`timescale 1ns/100ps
`default_nettype none

module motorPwmTop (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  start,
    input  wire logic                  stop,
    input  wire motorPwm_pkg::window_t windowLen,
    input  wire motorPwm_pkg::pwmLen_t pwmLenWant,
    input  wire motorPwm_pkg::pos_t    plLen,
    output wire logic                  pwm,
    output wire logic                  running,
    output wire motorPwm_pkg::step_t   step,
    output wire motorPwm_pkg::pos_t    lostCount
);

    // window end strobes from the timer
    wire logic windowLast1;
    wire logic windowLast;

    // sequencer owns the state and the step index
    stepSequencer i_stepSequencer (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .stop       (stop),
        .windowLast (windowLast),
        .running    (running),
        .step       (step)
    );

    stepTimer i_stepTimer (
        .clk         (clk),
        .reset       (reset),
        .running     (running),
        .windowLen   (windowLen),
        .windowLast1 (windowLast1),
        .windowLast  (windowLast)
    );

    // pulse generation and loss accounting follow the step windows
    pwmGenerator i_pwmGenerator (
        .clk         (clk),
        .reset       (reset),
        .running     (running),
        .windowLast1 (windowLast1),
        .windowLast  (windowLast),
        .step        (step),
        .pwmLenWant  (pwmLenWant),
        .plLen       (plLen),
        .pwm         (pwm),
        .lostCount   (lostCount)
    );

endmodule

`default_nettype wire

//--- motorPwm_assert.sv
`timescale 1ns/100ps
`default_nettype none

`include "motorPwm_cfg.svh"

module motorPwmAssert (
    input wire logic                clk,
    input wire logic                reset,
    input wire logic                start,
    input wire logic                running,
    input wire logic                pwm,
    input wire logic                windowLast,
    input wire motorPwm_pkg::step_t step
);

    // the step index never leaves the commutation range
    stepInRange: assert property (@(posedge clk) disable iff (reset)
        step < motorPwm_pkg::step_t'(`STEP_COUNT))
        else $error("step index left the commutation range");

    // the first running cycle must not carry a pulse left over from the last run
    pwmLowWhenIdle: assert property (@(posedge clk) disable iff (reset)
        (!running || !$past(running)) |-> !pwm)
        else $error("pwm high while or right after the sequence was idle");

    // a start from idle also puts the step back to 0
    stepOnWindowEnd: assert property (@(posedge clk) disable iff (reset)
        !$stable(step) |-> $past(windowLast) || $past(start && !running))
        else $error("step changed without a window end before it");

endmodule

bind motorPwmTop motorPwmAssert i_motorPwmAssert (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .running    (running),
    .pwm        (pwm),
    .windowLast (windowLast),
    .step       (step)
);

`default_nettype wire

//--- motorPwm_cfg.svh
`ifndef MOTORPWM_CFG_SVH
`define MOTORPWM_CFG_SVH

// width of the PWM period counter and of the wanted period length
`define PWM_LEN_WIDTH 12

// pulse sums, remainder, window accumulators and the loss total
`define POS_WIDTH 16

// commutation step index
`define STEP_WIDTH 4

// cycle counter inside one step window
`define WINDOW_WIDTH 25

// one electrical turn is split into this many commutation steps
`define STEP_COUNT 12

// the driver cannot switch cleanly below this many cycles of on-time
`define PWM_MIN_ON 256

// the loss total starts over when the sequence enters one of these steps
`define LOSS_RESET_STEP_A 0
`define LOSS_RESET_STEP_B 6

`endif

//--- motorPwm_pkg.sv
`default_nettype none

`include "motorPwm_cfg.svh"

package motorPwm_pkg;

    // PWM period length, both the running counter and the requested value
    typedef logic [`PWM_LEN_WIDTH-1:0] pwmLen_t;

    // pulse lengths in cycles
    // also used for the remainder, the wanted and real totals and the loss
    typedef logic [`POS_WIDTH-1:0] pos_t;

    // commutation step index, counts 0 up to STEP_COUNT-1
    typedef logic [`STEP_WIDTH-1:0] step_t;

    // cycles inside one step window
    typedef logic [`WINDOW_WIDTH-1:0] window_t;

    // states of the commutation sequencer
    // Stopping holds the sequence until the current window has run out
    typedef enum logic [1:0] {
        Idle,
        Run,
        Stopping
    } seqState_t;

endpackage

`default_nettype wire

//--- pwmGenerator.sv
`timescale 1ns/100ps
`default_nettype none

`include "motorPwm_cfg.svh"

module pwmGenerator (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  running,
    input  wire logic                  windowLast1,
    input  wire logic                  windowLast,
    input  wire motorPwm_pkg::step_t   step,
    input  wire motorPwm_pkg::pwmLen_t pwmLenWant,
    input  wire motorPwm_pkg::pos_t    plLen,
    output logic                       pwm,
    output motorPwm_pkg::pos_t         lostCount
);

    // period counter and reload tracking
    motorPwm_pkg::pwmLen_t periodCnt;
    logic                  windowLast1Q;
    logic                  reloadNow;
    logic                  reloadQ;
    logic                  periodStart;

    // pulse building
    motorPwm_pkg::pos_t    remainder;
    motorPwm_pkg::pos_t    posSum;
    logic                  sumLoad;
    motorPwm_pkg::pos_t    pulseCnt;
    logic                  pulseOn;

    // per-window accounting
    motorPwm_pkg::pos_t    wantCnt;
    motorPwm_pkg::pos_t    realCnt;
    motorPwm_pkg::pos_t    lossDiff;
    logic                  windowLastQ;
    logic                  lossRestart;

    // the period is cut short at the window end, when it runs out, or when
    // no pulse is requested at all
    // while idle the counter just keeps loading the wanted length
    assign reloadNow = !running
                    || windowLast1Q
                    || (periodCnt == motorPwm_pkg::pwmLen_t'(1))
                    || (plLen == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            windowLast1Q <= 1'b0;
            reloadQ      <= 1'b0;
            windowLastQ  <= 1'b0;
        end else begin
            windowLast1Q <= windowLast1;
            reloadQ      <= reloadNow;
            windowLastQ  <= windowLast;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            periodCnt <= '0;
        end else if (reloadNow) begin
            periodCnt <= pwmLenWant;
        end else begin
            periodCnt <= periodCnt - motorPwm_pkg::pwmLen_t'(1);
        end
    end

    // a period really begins only once the reloads have stopped
    // a run of back to back reloads gives a single start afterwards
    assign periodStart = reloadQ && !reloadNow;

    // short requests pile up in the remainder until the sum is long enough
    // to drive the switches, so no requested on-time is thrown away
    assign posSum  = remainder + plLen;
    assign sumLoad = (posSum >= motorPwm_pkg::pos_t'(`PWM_MIN_ON));

    always_ff @(posedge clk) begin
        if (reset) begin
            remainder <= '0;
        end else if (!running) begin
            remainder <= '0;
        end else if (periodStart) begin
            remainder <= sumLoad ? '0 : posSum;
        end
    end

    // the pulse may outlast the period when a large backlog is flushed
    always_ff @(posedge clk) begin
        if (reset) begin
            pulseCnt <= '0;
        end else if (!running) begin
            pulseCnt <= '0;
        end else if (periodStart && sumLoad) begin
            pulseCnt <= posSum;
        end else if (pulseOn) begin
            pulseCnt <= pulseCnt - motorPwm_pkg::pos_t'(1);
        end
    end

    assign pulseOn = (pulseCnt != '0);

    // the gate covers the single cycle in which the sequence has just
    // stopped and the counter has not yet been cleared
    assign pwm = running && pulseOn;

    // wanted versus delivered on-time inside the current window
    always_ff @(posedge clk) begin
        if (reset) begin
            wantCnt <= '0;
            realCnt <= '0;
        end else if (windowLast || !running) begin
            wantCnt <= '0;
            realCnt <= '0;
        end else begin
            if (periodStart) begin
                wantCnt <= wantCnt + plLen;
            end
            if (pwm) begin
                realCnt <= realCnt + motorPwm_pkg::pos_t'(1);
            end
        end
    end

    // the totals are cleared at windowLast, so keep the window's difference
    always_ff @(posedge clk) begin
        if (windowLast) begin
            lossDiff <= wantCnt - realCnt;
        end
    end

    // step has already moved on by the time windowLastQ is high, so the
    // restart happens when the sequence enters step 0 or step 6
    assign lossRestart = (step == motorPwm_pkg::step_t'(`LOSS_RESET_STEP_A))
                      || (step == motorPwm_pkg::step_t'(`LOSS_RESET_STEP_B));

    always_ff @(posedge clk) begin
        if (reset) begin
            lostCount <= '0;
        end else if (windowLastQ) begin
            if (lossRestart) begin
                lostCount <= lossDiff;
            end else begin
                lostCount <= lostCount + lossDiff;
            end
        end
    end

endmodule

`default_nettype wire

//--- stepSequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "motorPwm_cfg.svh"

module stepSequencer (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                start,
    input  wire logic                stop,
    input  wire logic                windowLast,
    output logic                     running,
    output motorPwm_pkg::step_t      step
);

    motorPwm_pkg::seqState_t state;
    motorPwm_pkg::seqState_t stateNext;
    logic                    stepAdvance;

    // the step moves on at every window end while running normally
    // in Stopping the last window finishes on the step it started with
    assign stepAdvance = (state == motorPwm_pkg::Run) && windowLast;

    always_comb begin
        stateNext = state;
        case (state)
            motorPwm_pkg::Idle: begin
                if (start) begin
                    stateNext = motorPwm_pkg::Run;
                end
            end
            motorPwm_pkg::Run: begin
                // stop is only noted here, the window still runs to its end
                if (stop) begin
                    stateNext = motorPwm_pkg::Stopping;
                end
            end
            motorPwm_pkg::Stopping: begin
                if (windowLast) begin
                    stateNext = motorPwm_pkg::Idle;
                end
            end
            default: begin
                stateNext = motorPwm_pkg::Idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= motorPwm_pkg::Idle;
        end else begin
            state <= stateNext;
        end
    end

    // a fresh start always begins at step 0, whatever step the last run ended on
    always_ff @(posedge clk) begin
        if (reset) begin
            step <= '0;
        end else if ((state == motorPwm_pkg::Idle) && start) begin
            step <= '0;
        end else if (stepAdvance) begin
            if (step >= motorPwm_pkg::step_t'(`STEP_COUNT - 1)) begin
                step <= '0;
            end else begin
                step <= step + motorPwm_pkg::step_t'(1);
            end
        end
    end

    // running follows the state register directly, so it rises together
    // with step being set to 0
    assign running = (state != motorPwm_pkg::Idle);

endmodule

`default_nettype wire

//--- stepTimer.sv
`timescale 1ns/100ps
`default_nettype none

module stepTimer (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  running,
    input  wire motorPwm_pkg::window_t windowLen,
    output logic                       windowLast1,
    output logic                       windowLast
);

    motorPwm_pkg::window_t windowCnt;
    motorPwm_pkg::window_t windowEnd;
    motorPwm_pkg::window_t windowEndPrev;

    // the window covers counts 0 up to windowLen-1
    assign windowEnd     = windowLen - motorPwm_pkg::window_t'(1);
    assign windowEndPrev = windowLen - motorPwm_pkg::window_t'(2);

    // the counter sits at zero whenever the sequence is idle, so the
    // first running cycle is always count 0 of a fresh window
    always_ff @(posedge clk) begin
        if (reset) begin
            windowCnt <= '0;
        end else if (!running) begin
            windowCnt <= '0;
        end else if (windowCnt >= windowEnd) begin
            // a shortened windowLen must not let the counter run away
            windowCnt <= '0;
        end else begin
            windowCnt <= windowCnt + motorPwm_pkg::window_t'(1);
        end
    end

    // windowLast1 is one cycle ahead of windowLast
    // the generator uses it to line up a period reload with the window end
    assign windowLast1 = running && (windowCnt == windowEndPrev);
    assign windowLast  = running && (windowCnt == windowEnd);

endmodule

`default_nettype wire

//--- tbClock.sv
`timescale 1ns/100ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic reset
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset covers the first five rising edges and is released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire
